/* verilog.f */
hdl/mipsPkg.sv
hdl/regFile.sv
hdl/operandFwd.sv
hdl/decodeCtrl.sv
hdl/branchUnit.sv
hdl/idExReg.sv
hdl/decodeStage.sv
dv/tbClock.sv
dv/decodeChecker.sv
dv/decodeTb.sv

/* dv/decodeTb.sv */
`default_nettype none

module decodeTb;

	localparam int resetCycles   = 8;
	localparam int preloadCycles = 10;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [1:0]  selA;
		logic [1:0]  selB;
		logic [31:0] resultM;
		logic [31:0] wbData;
		logic        flush;
		logic [1:0]  expPcSel;
		logic [31:0] expPcJump;
		logic [31:0] expPcReg;
		logic [31:0] expPcBranch;
		logic [31:0] expPcE;
		logic [31:0] expInstrE;
		logic [31:0] expOpAE;
		logic [31:0] expOpBE;
		logic [31:0] expImmE;
		logic        expMdStartE;
	} tableRow;

	logic        clk;
	logic        rstN;
	logic [31:0] instrD, pcD, wbData, resultM;
	logic [4:0]  wbAddr;
	logic        regWrite;
	logic        idExClr;
	logic [1:0]  fwdSelA, fwdSelB;
	logic [1:0]  pcSel;
	logic [31:0] pcJump, pcReg, pcBranch, pcE, instrE, opAE, opBE, immE;
	logic        mdStartE;
	tableRow     rows [$];
	tableRow     cur;
	logic        rowValid;
	int          rowId;
	int          testsDone, testsFailed, mismatches;
	int          cycleCount;
	logic [31:0] regModel [32];
	logic [31:0] rngState;

	tbClock clkGen (.clk(clk), .rstN(rstN));

	decodeStage dut_i (
		.clk(clk), .rstN(rstN), .instrD(instrD), .pcD(pcD),
		.wbAddr(wbAddr), .wbData(wbData), .regWrite(regWrite), .resultM(resultM),
		.fwdSelA(fwdSelA), .fwdSelB(fwdSelB), .idExClr(idExClr),
		.pcSel(pcSel), .pcJump(pcJump), .pcReg(pcReg), .pcBranch(pcBranch),
		.pcE(pcE), .instrE(instrE), .opAE(opAE), .opBE(opBE),
		.immE(immE), .mdStartE(mdStartE)
	);

	decodeChecker scoreboard (
		.clk(clk), .rstN(rstN), .rowValid(rowValid), .rowId(rowId),
		.pcSel(pcSel), .pcJump(pcJump), .pcReg(pcReg), .pcBranch(pcBranch),
		.pcE(pcE), .instrE(instrE), .opAE(opAE), .opBE(opBE), .immE(immE),
		.mdStartE(mdStartE), .expPcSel(cur.expPcSel), .expPcJump(cur.expPcJump),
		.expPcReg(cur.expPcReg), .expPcBranch(cur.expPcBranch), .expPcE(cur.expPcE),
		.expInstrE(cur.expInstrE), .expOpAE(cur.expOpAE), .expOpBE(cur.expOpBE),
		.expImmE(cur.expImmE), .expMdStartE(cur.expMdStartE),
		.testsDone(testsDone), .testsFailed(testsFailed), .mismatches(mismatches)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////
	function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
			input logic [5:0] funct);
		return {mipsPkg::opRtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
			input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] jType(input logic [5:0] op, input logic [25:0] index);
		return {op, index};
	endfunction

	// Expected outputs worked out from the decode rules
	task automatic addRow(input logic [31:0] instr, input logic [31:0] pc,
			input logic [1:0] selA = mipsPkg::fwdReg, input logic [1:0] selB = mipsPkg::fwdReg,
			input logic [31:0] resM = '0, input logic [31:0] wbd = '0, input logic flush = 1'b0);
		tableRow     r;
		logic [5:0]  op;
		logic [4:0]  rt;
		logic [31:0] a, b, ext, next4;
		logic        isRtype, cond;
		op      = instr[31:26];
		rt      = instr[20:16];
		isRtype = (op == mipsPkg::opRtype);
		a = (selA == mipsPkg::fwdResult) ? resM : (selA == mipsPkg::fwdWb) ? wbd
			: regModel[instr[25:21]];
		b = (selB == mipsPkg::fwdResult) ? resM : (selB == mipsPkg::fwdWb) ? wbd : regModel[rt];
		// Signed for memory offsets and branches, high half for lui
		if (op inside {mipsPkg::opLw, mipsPkg::opSw, mipsPkg::opBeq, mipsPkg::opBne,
				mipsPkg::opRegimm})
			ext = {{16{instr[15]}}, instr[15:0]};
		else if (op == mipsPkg::opLui)
			ext = {instr[15:0], 16'h0000};
		else
			ext = {16'h0000, instr[15:0]};
		next4 = pc + 32'd4;
		cond  = (op == mipsPkg::opBeq && a == b) || (op == mipsPkg::opBne && a != b)
			|| (op == mipsPkg::opRegimm && rt == mipsPkg::rtBltz && $signed(a) < 0)
			|| (op == mipsPkg::opRegimm && rt == mipsPkg::rtBgez && $signed(a) >= 0);
		r = '0;
		r.instr       = instr;
		r.pc          = pc;
		r.selA        = selA;
		r.selB        = selB;
		r.resultM     = resM;
		r.wbData      = wbd;
		r.flush       = flush;
		r.expPcJump   = {next4[31:28], instr[25:0], 2'b00};
		r.expPcReg    = a;
		r.expPcBranch = next4 + (ext << 2);
		if (op == mipsPkg::opJ || op == mipsPkg::opJal)
			r.expPcSel = mipsPkg::pcJump;
		else if (isRtype && instr[5:0] == mipsPkg::fnJr)
			r.expPcSel = mipsPkg::pcReg;
		else
			r.expPcSel = cond ? mipsPkg::pcBranch : mipsPkg::pcSeq;
		// Flushed rows leave a bubble in EX
		if (!flush) begin
			r.expPcE      = pc;
			r.expInstrE   = instr;
			r.expOpAE     = a;
			r.expOpBE     = b;
			r.expImmE     = ext;
			r.expMdStartE = isRtype && (instr[5:0] inside {mipsPkg::fnMult, mipsPkg::fnDiv});
		end
		rows.push_back(r);
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		// A live mult during reset, so only the reset can leave ID/EX empty
		instrD     = rType(1, 2, 0, mipsPkg::fnMult);
		pcD        = 32'hbfc0_0000;
		wbAddr     = '0;
		wbData     = '0;
		regWrite   = 1'b0;
		resultM    = '0;
		fwdSelA    = mipsPkg::fwdReg;
		fwdSelB    = mipsPkg::fwdReg;
		idExClr    = 1'b0;
		cur        = '0;
		rowValid   = 1'b0;
		rowId      = 0;
		cycleCount = 0;
		rngState   = 32'd42945;
		foreach (regModel[i]) regModel[i] = '0;
		for (int i = 1; i <= 8; i++) begin
			rngState    = xorshift(rngState);
			regModel[i] = rngState;
		end
		// Negative, zero, equal pair
		regModel[3] = 32'hffff_ff00;
		regModel[4] = '0;
		regModel[6] = regModel[5];

		// Register reads and r0
		addRow(rType(1, 2, 9, mipsPkg::fnAddu), 32'h0040_0000);
		addRow(rType(0, 3, 9, mipsPkg::fnAddu), 32'h0040_0004);
		addRow(rType(5, 6, 10, mipsPkg::fnSubu), 32'h0040_0008);
		// Forwarded operands
		addRow(rType(1, 2, 9, mipsPkg::fnAddu), 32'h0040_000c, mipsPkg::fwdResult,
			mipsPkg::fwdWb, 32'h1234_5678, 32'h9abc_def0);
		addRow(rType(7, 0, 0, mipsPkg::fnJr), 32'h0040_0010, mipsPkg::fwdResult,
			mipsPkg::fwdReg, 32'h0040_2000);
		addRow(rType(8, 0, 0, mipsPkg::fnJr), 32'h0040_0014);
		// Immediate modes
		addRow(iType(mipsPkg::opOri, 1, 9, 16'h8001), 32'h0040_0018);
		addRow(iType(mipsPkg::opLw, 2, 10, 16'hfff0), 32'h0040_001c);
		addRow(iType(mipsPkg::opSw, 3, 4, 16'h8000), 32'h0040_0020);
		addRow(iType(mipsPkg::opLui, 0, 11, 16'habcd), 32'h0040_0024);
		// Branches both ways
		addRow(iType(mipsPkg::opBeq, 5, 6, 16'h0010), 32'h0040_0028);
		addRow(iType(mipsPkg::opBeq, 1, 2, 16'hfffc), 32'h0040_002c);
		addRow(iType(mipsPkg::opBne, 1, 2, 16'hfff0), 32'h0040_0030);
		addRow(iType(mipsPkg::opBne, 5, 6, 16'h0020), 32'h0040_0034);
		addRow(iType(mipsPkg::opRegimm, 3, mipsPkg::rtBltz, 16'h0008), 32'h0040_0038);
		addRow(iType(mipsPkg::opRegimm, 4, mipsPkg::rtBltz, 16'h0008), 32'h0040_003c);
		addRow(iType(mipsPkg::opRegimm, 4, mipsPkg::rtBgez, 16'hff00), 32'h0040_0040);
		addRow(iType(mipsPkg::opRegimm, 3, mipsPkg::rtBgez, 16'hff00), 32'h0040_0044);
		// Equal only once both come from writeback
		addRow(iType(mipsPkg::opBeq, 1, 2, 16'h0004), 32'h0040_0048, mipsPkg::fwdWb,
			mipsPkg::fwdWb, '0, 32'h0000_0055);
		// Jumps and the mul/div strobe
		addRow(jType(mipsPkg::opJ, 26'h0123456), 32'ha000_0100);
		addRow(jType(mipsPkg::opJal, 26'h3ffffff), 32'h5fff_fffc);
		addRow(rType(1, 2, 0, mipsPkg::fnMult), 32'h0040_004c);
		addRow(rType(7, 8, 0, mipsPkg::fnDiv), 32'h0040_0050);
		// Flushes, then a normal row behind them
		addRow(rType(1, 2, 0, mipsPkg::fnMult), 32'h0040_0054, mipsPkg::fwdReg,
			mipsPkg::fwdReg, '0, '0, 1'b1);
		addRow(iType(mipsPkg::opLui, 0, 12, 16'h7777), 32'h0040_0058, mipsPkg::fwdReg,
			mipsPkg::fwdReg, '0, '0, 1'b1);
		addRow(rType(5, 6, 13, mipsPkg::fnAddu), 32'h0040_005c);

		wait (rstN === 1'b1);
		// Preload r1..r8 through the writeback port
		for (int i = 1; i <= 8; i++) begin
			@(posedge clk);
			wbAddr   <= 5'(i);
			wbData   <= regModel[i];
			regWrite <= 1'b1;
		end
		// Write to r0 must not stick
		@(posedge clk);
		wbAddr <= '0;
		wbData <= 32'hdead_beef;
		@(posedge clk);
		regWrite <= 1'b0;

		foreach (rows[k]) begin
			@(posedge clk);
			instrD   <= rows[k].instr;
			pcD      <= rows[k].pc;
			fwdSelA  <= rows[k].selA;
			fwdSelB  <= rows[k].selB;
			resultM  <= rows[k].resultM;
			wbData   <= rows[k].wbData;
			idExClr  <= rows[k].flush;
			cur      <= rows[k];
			rowValid <= 1'b1;
			rowId    <= k;
		end
		// Idle cycle drains the last row out of ID/EX
		@(posedge clk);
		instrD   <= '0;
		pcD      <= '0;
		fwdSelA  <= mipsPkg::fwdReg;
		fwdSelB  <= mipsPkg::fwdReg;
		idExClr  <= 1'b0;
		rowValid <= 1'b0;
		while (testsDone < rows.size() + 1) @(posedge clk);

		$display("Tests: %0d run, %0d failed, %0d mismatches",
			testsDone, testsFailed, mismatches);
		if (testsFailed == 0 && mismatches == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Reset, preload, and four cycles per row at most
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > resetCycles + preloadCycles + 4 * rows.size()) begin
			$display("Timeout: run still busy after %0d cycles", cycleCount);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dv/decodeChecker.sv */
`default_nettype none

module decodeChecker (
	input  logic        clk,
	input  logic        rstN,
	// Row currently on the DUT inputs
	input  logic        rowValid,
	input  int          rowId,
	// DUT outputs
	input  logic [1:0]  pcSel,
	input  logic [31:0] pcJump, pcReg, pcBranch,
	input  logic [31:0] pcE, instrE, opAE, opBE, immE,
	input  logic        mdStartE,
	// Expected values for that row
	input  logic [1:0]  expPcSel,
	input  logic [31:0] expPcJump, expPcReg, expPcBranch,
	input  logic [31:0] expPcE, expInstrE, expOpAE, expOpBE, expImmE,
	input  logic        expMdStartE,
	output int          testsDone,
	output int          testsFailed,
	output int          mismatches
);

	logic        resetChecked;
	int          resetErrs;
	// ID/EX side of the previous row, due one cycle later
	logic        pendValid;
	int          pendId;
	int          pendErrs;
	logic [31:0] pendPcE, pendInstrE, pendOpAE, pendOpBE, pendImmE;
	logic        pendMdStartE;

	initial begin
		testsDone    = 0;
		testsFailed  = 0;
		mismatches   = 0;
		resetChecked = 1'b0;
		pendValid    = 1'b0;
	end

	task automatic compareWord(input string name, input logic [31:0] expVal,
			input logic [31:0] gotVal, inout int errCnt);
		if (gotVal !== expVal) begin
			$display("Mismatch at %0t: %s expected 0x%08h, got 0x%08h",
				$time, name, expVal, gotVal);
			errCnt++;
			mismatches++;
		end
	endtask

	// One line per finished test
	task automatic finishTest(input string label, input int errCnt);
		testsDone++;
		if (errCnt == 0) begin
			$display("%s: pass", label);
		end else begin
			testsFailed++;
			$display("%s: FAIL with %0d mismatches", label, errCnt);
		end
	endtask

	////////////////////////////////////////
	// Sampling at the falling edge
	////////////////////////////////////////
	always @(negedge clk) begin
		if (rstN && !resetChecked) begin
			// EX side must come out of reset empty
			resetErrs = 0;
			compareWord("pcE", '0, pcE, resetErrs);
			compareWord("instrE", '0, instrE, resetErrs);
			compareWord("opAE", '0, opAE, resetErrs);
			compareWord("opBE", '0, opBE, resetErrs);
			compareWord("immE", '0, immE, resetErrs);
			compareWord("mdStartE", '0, 32'(mdStartE), resetErrs);
			finishTest("reset", resetErrs);
			resetChecked = 1'b1;
		end
		if (rstN && pendValid) begin
			compareWord("pcE", pendPcE, pcE, pendErrs);
			compareWord("instrE", pendInstrE, instrE, pendErrs);
			compareWord("opAE", pendOpAE, opAE, pendErrs);
			compareWord("opBE", pendOpBE, opBE, pendErrs);
			compareWord("immE", pendImmE, immE, pendErrs);
			compareWord("mdStartE", 32'(pendMdStartE), 32'(mdStartE), pendErrs);
			finishTest($sformatf("row %0d", pendId), pendErrs);
		end
		pendValid = rstN && rowValid;
		if (pendValid) begin
			// Next-PC outputs settle in the same cycle
			pendErrs = 0;
			compareWord("pcSel", 32'(expPcSel), 32'(pcSel), pendErrs);
			compareWord("pcJump", expPcJump, pcJump, pendErrs);
			compareWord("pcReg", expPcReg, pcReg, pendErrs);
			compareWord("pcBranch", expPcBranch, pcBranch, pendErrs);
			pendId       = rowId;
			pendPcE      = expPcE;
			pendInstrE   = expInstrE;
			pendOpAE     = expOpAE;
			pendOpBE     = expOpBE;
			pendImmE     = expImmE;
			pendMdStartE = expMdStartE;
		end
	end

endmodule

`default_nettype wire

/* dv/tbClock.sv */
`default_nettype none

module tbClock (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod  = 5;
	localparam int resetCycles = 8;

	// 10 unit period
	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Held low over the first eight rising edges
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`default_nettype none

module decodeStage (
	input  logic                                clk,
	input  logic                                rstN,
	input  mipsPkg::instrWord                   instrD,
	input  logic [mipsPkg::dataWidth-1:0]       pcD,
	input  logic [mipsPkg::regAddrWidth-1:0]    wbAddr,
	input  logic [mipsPkg::dataWidth-1:0]       wbData,
	input  logic                                regWrite,
	input  logic [mipsPkg::dataWidth-1:0]       resultM,
	input  logic [1:0]                          fwdSelA,
	input  logic [1:0]                          fwdSelB,
	input  logic                                idExClr,
	output logic [1:0]                          pcSel,
	output logic [mipsPkg::dataWidth-1:0]       pcJump,
	output logic [mipsPkg::dataWidth-1:0]       pcReg,
	output logic [mipsPkg::dataWidth-1:0]       pcBranch,
	output logic [mipsPkg::dataWidth-1:0]       pcE,
	output mipsPkg::instrWord                   instrE,
	output logic [mipsPkg::dataWidth-1:0]       opAE,
	output logic [mipsPkg::dataWidth-1:0]       opBE,
	output logic [mipsPkg::dataWidth-1:0]       immE,
	output logic                                mdStartE
);

	logic [mipsPkg::dataWidth-1:0] rd1;
	logic [mipsPkg::dataWidth-1:0] rd2;
	logic [mipsPkg::dataWidth-1:0] opA;
	logic [mipsPkg::dataWidth-1:0] opB;
	logic [mipsPkg::dataWidth-1:0] immExt;
	logic [2:0]                    brClass;
	logic                          mdStart;

	////////////////////////////////////////
	// Operand path
	////////////////////////////////////////
	regFile rf (
		.clk(clk), .rstN(rstN),
		.rs(instrD.r.rs), .rt(instrD.r.rt),
		.wbAddr(wbAddr), .wbData(wbData), .regWrite(regWrite),
		.rd1(rd1), .rd2(rd2)
	);

	// Stale register values replaced here
	operandFwd fwd (
		.clk(clk), .fwdSelA(fwdSelA), .fwdSelB(fwdSelB),
		.rd1(rd1), .rd2(rd2), .resultM(resultM), .wbData(wbData),
		.opA(opA), .opB(opB)
	);

	////////////////////////////////////////
	// Control and branch resolution
	////////////////////////////////////////
	decodeCtrl ctrl (
		.instr(instrD), .extOp(), .immExt(immExt),
		.brClass(brClass), .mdStart(mdStart)
	);

	branchUnit branch (
		.instr(instrD), .pc(pcD), .opA(opA), .opB(opB),
		.immExt(immExt), .brClass(brClass), .pcSel(pcSel),
		.pcJump(pcJump), .pcReg(pcReg), .pcBranch(pcBranch)
	);

	// Into EX
	idExReg idEx (
		.clk(clk), .rstN(rstN), .idExClr(idExClr),
		.pcD(pcD), .instrD(instrD), .opA(opA), .opB(opB),
		.immExt(immExt), .mdStart(mdStart),
		.pcE(pcE), .instrE(instrE), .opAE(opAE), .opBE(opBE),
		.immE(immE), .mdStartE(mdStartE)
	);

endmodule

`default_nettype wire

/* hdl/idExReg.sv */
`default_nettype none

module idExReg (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic                            idExClr,
	input  logic [mipsPkg::dataWidth-1:0]   pcD,
	input  mipsPkg::instrWord               instrD,
	input  logic [mipsPkg::dataWidth-1:0]   opA,
	input  logic [mipsPkg::dataWidth-1:0]   opB,
	input  logic [mipsPkg::dataWidth-1:0]   immExt,
	input  logic                            mdStart,
	output logic [mipsPkg::dataWidth-1:0]   pcE,
	output mipsPkg::instrWord               instrE,
	output logic [mipsPkg::dataWidth-1:0]   opAE,
	output logic [mipsPkg::dataWidth-1:0]   opBE,
	output logic [mipsPkg::dataWidth-1:0]   immE,
	output logic                            mdStartE
);

	////////////////////////////////////////
	// ID/EX stage register
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		// Flush wins over new data
		// All-zero instruction decodes as nop
		if (!rstN || idExClr) begin
			pcE      <= '0;
			instrE   <= '0;
			opAE     <= '0;
			opBE     <= '0;
			immE     <= '0;
			mdStartE <= 1'b0;
		end else begin
			// Decode results for EX
			pcE      <= pcD;
			instrE   <= instrD;
			opAE     <= opA;
			opBE     <= opB;
			immE     <= immExt;
			// mul/div unit start, one pulse per instruction
			mdStartE <= mdStart;
		end
	end

endmodule

`default_nettype wire

/* hdl/branchUnit.sv */
`default_nettype none

module branchUnit (
	input  mipsPkg::instrWord               instr,
	input  logic [mipsPkg::dataWidth-1:0]   pc,
	input  logic [mipsPkg::dataWidth-1:0]   opA,
	input  logic [mipsPkg::dataWidth-1:0]   opB,
	input  logic [mipsPkg::dataWidth-1:0]   immExt,
	input  logic [2:0]                      brClass,
	output logic [1:0]                      pcSel,
	output logic [mipsPkg::dataWidth-1:0]   pcJump,
	output logic [mipsPkg::dataWidth-1:0]   pcReg,
	output logic [mipsPkg::dataWidth-1:0]   pcBranch
);

	logic [mipsPkg::dataWidth-1:0] pcPlus4;
	logic                          aEqB;
	logic                          aNeg;
	logic                          takeBranch;
	logic                          isJump;
	logic                          isJr;

	////////////////////////////////////////
	// Targets
	////////////////////////////////////////
	assign pcPlus4  = pc + 32'd4;
	// Region bits from pc+4, word index below
	assign pcJump   = {pcPlus4[31:28], instr.j.index26, 2'b00};
	assign pcReg    = opA;
	// Word offset
	assign pcBranch = pcPlus4 + {immExt[mipsPkg::dataWidth-3:0], 2'b00};

	////////////////////////////////////////
	// Condition and select
	////////////////////////////////////////
	// Compare on forwarded values
	assign aEqB = (opA == opB);
	assign aNeg = opA[mipsPkg::dataWidth-1];

	always_comb begin
		case (brClass)
			mipsPkg::brEq:  takeBranch = aEqB;
			mipsPkg::brNe:  takeBranch = !aEqB;
			mipsPkg::brLtz: takeBranch = aNeg;
			mipsPkg::brGez: takeBranch = !aNeg;
			default:        takeBranch = 1'b0;
		endcase
	end

	assign isJump = (instr.j.op == mipsPkg::opJ) || (instr.j.op == mipsPkg::opJal);
	assign isJr   = (instr.r.op == mipsPkg::opRtype) && (instr.r.funct == mipsPkg::fnJr);

	// Jumps first, then jr, then a taken branch
	assign pcSel = isJump     ? mipsPkg::pcJump :
	               isJr       ? mipsPkg::pcReg :
	               takeBranch ? mipsPkg::pcBranch : mipsPkg::pcSeq;

endmodule

`default_nettype wire

/* hdl/decodeCtrl.sv */
`default_nettype none

module decodeCtrl (
	input  mipsPkg::instrWord               instr,
	output logic [1:0]                      extOp,
	output logic [mipsPkg::dataWidth-1:0]   immExt,
	output logic [2:0]                      brClass,
	output logic                            mdStart
);

	logic [15:0] imm16;

	assign imm16 = instr.i.imm16;

	////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////
	always_comb begin
		// Defaults cover nop and unsupported codes
		extOp   = mipsPkg::extZero;
		brClass = mipsPkg::brNone;
		mdStart = 1'b0;
		case (instr.r.op)
			mipsPkg::opRtype: begin
				// funct picks the ALU or mul/div op
				case (instr.r.funct)
					mipsPkg::fnMult,
					mipsPkg::fnDiv: mdStart = 1'b1;
					mipsPkg::fnAddu,
					mipsPkg::fnSubu,
					mipsPkg::fnJr:  extOp = mipsPkg::extZero;
					default:        mdStart = 1'b0;
				endcase
			end
			mipsPkg::opRegimm: begin
				// Sub-op sits in rt
				extOp = mipsPkg::extSign;
				case (instr.i.rt)
					mipsPkg::rtBltz: brClass = mipsPkg::brLtz;
					mipsPkg::rtBgez: brClass = mipsPkg::brGez;
					default:         brClass = mipsPkg::brNone;
				endcase
			end
			mipsPkg::opBeq: begin
				extOp   = mipsPkg::extSign;
				brClass = mipsPkg::brEq;
			end
			mipsPkg::opBne: begin
				extOp   = mipsPkg::extSign;
				brClass = mipsPkg::brNe;
			end
			// Address offsets are signed
			mipsPkg::opLw,
			mipsPkg::opSw:  extOp = mipsPkg::extSign;
			mipsPkg::opLui: extOp = mipsPkg::extUpper;
			// logical immediates stay unsigned
			mipsPkg::opOri: extOp = mipsPkg::extZero;
			default:        extOp = mipsPkg::extZero;
		endcase
	end

	////////////////////////////////////////
	// Immediate extender
	////////////////////////////////////////
	always_comb begin
		case (extOp)
			mipsPkg::extSign:
				immExt = {{(mipsPkg::dataWidth-16){imm16[15]}}, imm16};
			// lui puts imm16 in the high half
			mipsPkg::extUpper:
				immExt = {imm16, {(mipsPkg::dataWidth-16){1'b0}}};
			default:
				immExt = {{(mipsPkg::dataWidth-16){1'b0}}, imm16};
		endcase
	end

endmodule

`default_nettype wire

/* hdl/operandFwd.sv */
`default_nettype none

module operandFwd (
	input  logic                            clk,
	input  logic [1:0]                      fwdSelA,
	input  logic [1:0]                      fwdSelB,
	input  logic [mipsPkg::dataWidth-1:0]   rd1,
	input  logic [mipsPkg::dataWidth-1:0]   rd2,
	input  logic [mipsPkg::dataWidth-1:0]   resultM,
	input  logic [mipsPkg::dataWidth-1:0]   wbData,
	output logic [mipsPkg::dataWidth-1:0]   opA,
	output logic [mipsPkg::dataWidth-1:0]   opB
);

	// Three-way source pick, shared by both operands
	function automatic logic [mipsPkg::dataWidth-1:0] pickOperand(
		input logic [1:0]                    sel,
		input logic [mipsPkg::dataWidth-1:0] regVal,
		input logic [mipsPkg::dataWidth-1:0] exMemVal,
		input logic [mipsPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			mipsPkg::fwdResult: pickOperand = exMemVal;
			mipsPkg::fwdWb:     pickOperand = wbVal;
			default:            pickOperand = regVal;
		endcase
	endfunction

	// rs side and rt side
	assign opA = pickOperand(fwdSelA, rd1, resultM, wbData);
	assign opB = pickOperand(fwdSelB, rd2, resultM, wbData);

	// Hazard unit never sends code 3
	fwdSelALegal: assert property (@(posedge clk) fwdSelA != 2'd3)
		else $error("operandFwd: fwdSelA carries illegal code 3");
	fwdSelBLegal: assert property (@(posedge clk) fwdSelB != 2'd3)
		else $error("operandFwd: fwdSelB carries illegal code 3");

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
	input  logic                                clk,
	input  logic                                rstN,
	input  logic [mipsPkg::regAddrWidth-1:0]    rs,
	input  logic [mipsPkg::regAddrWidth-1:0]    rt,
	input  logic [mipsPkg::regAddrWidth-1:0]    wbAddr,
	input  logic [mipsPkg::dataWidth-1:0]       wbData,
	input  logic                                regWrite,
	output logic [mipsPkg::dataWidth-1:0]       rd1,
	output logic [mipsPkg::dataWidth-1:0]       rd2
);

	// 32 words, entry 0 never written
	logic [mipsPkg::dataWidth-1:0] regs [0:(1 << mipsPkg::regAddrWidth)-1];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			// Whole file back to zero
			for (int i = 0; i < (1 << mipsPkg::regAddrWidth); i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && (wbAddr != '0)) begin
			regs[wbAddr] <= wbData;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	// Combinational, old value during a same-cycle write
	// Hazard unit picks fwdWb for that case
	assign rd1 = (rs == '0) ? '0 : regs[rs];
	assign rd2 = (rt == '0) ? '0 : regs[rt];

	// Writeback must present real data with the enable
	wbDataKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		regWrite |-> !$isunknown(wbData)
	) else $error("regFile: unknown wbData with regWrite high");

endmodule

`default_nettype wire

/* hdl/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 5;

	////////////////////////////////////////
	// Opcode and funct codes
	////////////////////////////////////////
	// Primary opcode, bits 31:26
	localparam logic [5:0] opRtype  = 6'h00;
	localparam logic [5:0] opRegimm = 6'h01;
	localparam logic [5:0] opJ      = 6'h02;
	localparam logic [5:0] opJal    = 6'h03;
	localparam logic [5:0] opBeq    = 6'h04;
	localparam logic [5:0] opBne    = 6'h05;
	localparam logic [5:0] opOri    = 6'h0d;
	localparam logic [5:0] opLui    = 6'h0f;
	localparam logic [5:0] opLw     = 6'h23;
	localparam logic [5:0] opSw     = 6'h2b;

	// R-type funct, bits 5:0
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnMult = 6'h18;
	localparam logic [5:0] fnDiv  = 6'h1a;

	// REGIMM sub-op lives in rt
	localparam logic [4:0] rtBltz = 5'h00;
	localparam logic [4:0] rtBgez = 5'h01;

	////////////////////////////////////////
	// Select encodings
	////////////////////////////////////////
	// Operand source, 3 is illegal
	localparam logic [1:0] fwdReg    = 2'd0;
	localparam logic [1:0] fwdResult = 2'd1;
	localparam logic [1:0] fwdWb     = 2'd2;

	// Immediate extension mode
	localparam logic [1:0] extZero  = 2'd0;
	localparam logic [1:0] extSign  = 2'd1;
	localparam logic [1:0] extUpper = 2'd2;

	// Next-PC source
	localparam logic [1:0] pcSeq    = 2'd0;
	localparam logic [1:0] pcBranch = 2'd1;
	localparam logic [1:0] pcJump   = 2'd2;
	localparam logic [1:0] pcReg    = 2'd3;

	// Branch condition class
	localparam logic [2:0] brNone = 3'd0;
	localparam logic [2:0] brEq   = 3'd1;
	localparam logic [2:0] brNe   = 3'd2;
	localparam logic [2:0] brLtz  = 3'd3;
	localparam logic [2:0] brGez  = 3'd4;

	////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} iFields;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] index26;
	} jFields;

	// Same 32 bits, three formats
	typedef union packed {
		rFields r;
		iFields i;
		jFields j;
	} instrWord;

endpackage

`default_nettype wire
